// ==== cu_setup_params.svh ====
`ifndef CU_SETUP_PARAMS_SVH
`define CU_SETUP_PARAMS_SVH

// Descriptor word and byte address width
`define SETUP_ADDR_W 64

// Memory word, index and counter width
`define SETUP_DATA_W 32

// log2 of the bytes in one memory word
`define SETUP_WORD_SHIFT 2

// Request FIFO sizing
`define SETUP_FIFO_DEPTH 16

// Four slots stay free for the pushes still in flight when the engine stops
`define SETUP_PROG_THRESH 12

`endif

// ==== setup_mem_pkg.sv ====
`include "cu_setup_params.svh"

package setup_mem_pkg;

    // Byte address into the setup structures
    typedef logic [`SETUP_ADDR_W-1:0] setup_addr_t;

    // Entry index or entry count
    typedef logic [`SETUP_DATA_W-1:0] setup_count_t;

    // Structure a read belongs to
    typedef enum logic {
        kind_program = 1'b0,
        kind_flush   = 1'b1
    } request_kind_t;

endpackage : setup_mem_pkg

// ==== setup_ctrl_pkg.sv ====
package setup_ctrl_pkg;

    // Sequencer states, program phase first, then flush phase
    typedef enum logic [3:0] {
        st_reset       = 4'd0,
        st_idle        = 4'd1,
        st_prog_start  = 4'd2,
        st_prog_busy   = 4'd3,
        st_prog_pause  = 4'd4,
        st_prog_done   = 4'd5,
        st_flush_start = 4'd6,
        st_flush_busy  = 4'd7,
        st_flush_pause = 4'd8,
        st_flush_done  = 4'd9
    } setup_state_t;

    // Phase currently being read
    typedef enum logic {
        phase_program = 1'b0,
        phase_flush   = 1'b1
    } setup_phase_t;

endpackage : setup_ctrl_pkg

// ==== setup_input_stage.sv ====
`timescale 1ns/1ps
`include "cu_setup_params.svh"

module setup_input_stage (
    input  logic                         ap_clk,
    input  logic                         areset_cu_setup,
    input  logic                         descriptor_valid,
    input  setup_mem_pkg::setup_addr_t   descriptor_base,
    input  setup_mem_pkg::setup_addr_t   descriptor_size,
    input  logic                         cu_flush,
    input  logic                         response_valid,
    input  setup_ctrl_pkg::setup_phase_t phase,
    input  logic                         counter_load,
    output logic                         descriptor_start,
    output logic                         flush_seen,
    output setup_mem_pkg::setup_addr_t   base_address,
    output setup_mem_pkg::setup_count_t  read_first,
    output setup_mem_pkg::setup_count_t  read_count,
    output logic                         responses_zero
);

    import setup_mem_pkg::*;
    import setup_ctrl_pkg::*;

    logic         valid_reg;
    logic         valid_dly;
    logic         flush_reg;
    logic         response_reg;
    setup_addr_t  size_reg;
    setup_count_t prog_count;
    setup_count_t flush_end;
    setup_count_t flush_count;
    setup_count_t response_count;

    // --------------------------------------------------
    // Registered strobes
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_cu_setup) begin
            valid_reg    <= 1'b0;
            valid_dly    <= 1'b0;
            flush_reg    <= 1'b0;
            response_reg <= 1'b0;
        end else begin
            valid_reg    <= descriptor_valid;
            valid_dly    <= valid_reg;
            flush_reg    <= cu_flush;
            response_reg <= response_valid;
        end
    end

    // Rising edge of the registered valid level
    assign descriptor_start = valid_reg & ~valid_dly;

    // Descriptor words held for the whole job
    always_ff @(posedge ap_clk) begin
        if (descriptor_valid) begin
            base_address <= descriptor_base;
            size_reg     <= descriptor_size;
        end
    end

    // Flush request stays pending until the next job
    always_ff @(posedge ap_clk) begin
        if (areset_cu_setup) begin
            flush_seen <= 1'b0;
        end else if (flush_reg) begin
            flush_seen <= 1'b1;
        end else if (descriptor_start) begin
            flush_seen <= 1'b0;
        end
    end

    // --------------------------------------------------
    // Phase bounds
    // --------------------------------------------------
    assign prog_count  = {1'b0, size_reg[`SETUP_DATA_W-1:1]};
    assign flush_end   = size_reg[`SETUP_ADDR_W-1:`SETUP_DATA_W];
    assign flush_count = (flush_end > prog_count) ? flush_end - prog_count : '0;
    assign read_first  = (phase == phase_flush) ? prog_count : '0;
    assign read_count  = (phase == phase_flush) ? flush_count : prog_count;

    // Outstanding responses of the current phase
    always_ff @(posedge ap_clk) begin
        if (areset_cu_setup) begin
            response_count <= '0;
        end else if (counter_load) begin
            response_count <= read_count;
        end else if (response_reg && !responses_zero) begin
            response_count <= response_count - 1'b1;
        end
    end

    assign responses_zero = (response_count == '0);

endmodule : setup_input_stage

// ==== setup_sequencer.sv ====
`timescale 1ns/1ps

module setup_sequencer (
    input  logic                         ap_clk,
    input  logic                         areset_cu_setup,
    input  logic                         descriptor_start,
    input  logic                         flush_seen,
    input  logic                         engine_done,
    input  logic                         responses_zero,
    input  logic                         fifo_empty,
    input  logic                         fifo_prog_full,
    output setup_ctrl_pkg::setup_phase_t phase,
    output logic                         counter_load,
    output logic                         engine_start,
    output logic                         engine_pause,
    output logic                         done
);

    import setup_ctrl_pkg::*;

    setup_state_t state;
    setup_state_t next_state;
    logic         phase_done;

    // All issued, all drained, all answered
    assign phase_done = engine_done & fifo_empty & responses_zero;

    always_ff @(posedge ap_clk) begin
        if (areset_cu_setup) begin
            state <= st_reset;
        end else begin
            state <= next_state;
        end
    end

    // --------------------------------------------------
    // Next state
    // --------------------------------------------------
    always_comb begin
        next_state = state;
        case (state)
            st_reset: begin
                next_state = st_idle;
            end
            st_idle: begin
                if (descriptor_start) begin
                    next_state = st_prog_start;
                end
            end
            st_prog_start: begin
                next_state = st_prog_busy;
            end
            st_prog_busy: begin
                if (phase_done) begin
                    next_state = st_prog_done;
                end else if (fifo_prog_full) begin
                    next_state = st_prog_pause;
                end
            end
            st_prog_pause: begin
                if (!fifo_prog_full) begin
                    next_state = st_prog_busy;
                end
            end
            st_prog_done: begin
                if (flush_seen) begin
                    next_state = st_flush_start;
                end
            end
            st_flush_start: begin
                next_state = st_flush_busy;
            end
            st_flush_busy: begin
                if (phase_done) begin
                    next_state = st_flush_done;
                end else if (fifo_prog_full) begin
                    next_state = st_flush_pause;
                end
            end
            st_flush_pause: begin
                if (!fifo_prog_full) begin
                    next_state = st_flush_busy;
                end
            end
            st_flush_done: begin
                next_state = st_idle;
            end
            default: begin
                next_state = st_reset;
            end
        endcase
    end

    // --------------------------------------------------
    // Outputs decoded from the state
    // --------------------------------------------------
    assign phase = (state inside {st_flush_start, st_flush_busy, st_flush_pause, st_flush_done})
                   ? phase_flush : phase_program;

    // One cycle each, the start states never repeat
    assign engine_start = (state == st_prog_start) || (state == st_flush_start);
    assign counter_load = engine_start;

    assign engine_pause = (state == st_prog_pause) || (state == st_flush_pause);
    assign done         = (state == st_flush_done);

endmodule : setup_sequencer

// ==== read_request_engine.sv ====
`timescale 1ns/1ps
`include "cu_setup_params.svh"

module read_request_engine (
    input  logic                          ap_clk,
    input  logic                          areset_cu_setup,
    input  logic                          engine_start,
    input  logic                          engine_pause,
    input  setup_ctrl_pkg::setup_phase_t  phase,
    input  setup_mem_pkg::setup_addr_t    base_address,
    input  setup_mem_pkg::setup_count_t   read_first,
    input  setup_mem_pkg::setup_count_t   read_count,
    output logic                          push,
    output setup_mem_pkg::setup_addr_t    push_address,
    output setup_mem_pkg::request_kind_t  push_kind,
    output logic                          engine_done
);

    import setup_mem_pkg::*;
    import setup_ctrl_pkg::*;

    setup_count_t index;
    setup_count_t remaining;
    logic         running;

    // --------------------------------------------------
    // Run control
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_cu_setup) begin
            running     <= 1'b0;
            push        <= 1'b0;
            engine_done <= 1'b0;
        end else if (engine_start) begin
            // Empty range finishes at once
            running     <= (read_count != '0);
            push        <= 1'b0;
            engine_done <= (read_count == '0);
        end else if (running && !engine_pause) begin
            push <= 1'b1;
            if (remaining == setup_count_t'(1)) begin
                running     <= 1'b0;
                engine_done <= 1'b1;
            end
        end else begin
            push <= 1'b0;
        end
    end

    // --------------------------------------------------
    // Index walk and request payload
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (engine_start) begin
            index     <= read_first;
            remaining <= read_count;
        end else if (running && !engine_pause) begin
            index        <= index + 1'b1;
            remaining    <= remaining - 1'b1;
            push_address <= base_address + (setup_addr_t'(index) << `SETUP_WORD_SHIFT);
            push_kind    <= (phase == phase_flush) ? kind_flush : kind_program;
        end
    end

endmodule : read_request_engine

// ==== request_fifo.sv ====
`timescale 1ns/1ps
`include "cu_setup_params.svh"

module request_fifo #(
    parameter int DEPTH       = `SETUP_FIFO_DEPTH,
    parameter int PROG_THRESH = `SETUP_PROG_THRESH
) (
    input  logic                         ap_clk,
    input  logic                         areset_cu_setup,
    input  logic                         push,
    input  setup_mem_pkg::setup_addr_t   push_address,
    input  setup_mem_pkg::request_kind_t push_kind,
    input  logic                         request_ready,
    output logic                         request_valid,
    output setup_mem_pkg::setup_addr_t   request_address,
    output setup_mem_pkg::request_kind_t request_kind,
    output logic                         empty,
    output logic                         prog_full
);

    import setup_mem_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    setup_addr_t      addr_mem [DEPTH];
    request_kind_t    kind_mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] fill;
    logic             do_push;
    logic             do_pop;

    // Wraps at DEPTH, also for depths that are not a power of two
    function automatic logic [PTR_W-1:0] ptr_step(input logic [PTR_W-1:0] ptr);
        ptr_step = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign do_pop  = request_valid & request_ready;
    assign do_push = push & (fill != CNT_W'(DEPTH));

    always_ff @(posedge ap_clk) begin
        if (do_push) begin
            addr_mem[wr_ptr] <= push_address;
            kind_mem[wr_ptr] <= push_kind;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (areset_cu_setup) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= ptr_step(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_step(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
        end
    end

    // Show-ahead head of the queue
    assign empty           = (fill == '0);
    assign request_valid   = ~empty;
    assign request_address = addr_mem[rd_ptr];
    assign request_kind    = kind_mem[rd_ptr];
    assign prog_full       = (fill >= CNT_W'(PROG_THRESH));

endmodule : request_fifo

// ==== cu_setup_top.sv ====
`timescale 1ns/1ps

module cu_setup_top (
    input  logic                         ap_clk,
    input  logic                         areset_cu_setup,
    input  logic                         descriptor_valid,
    input  setup_mem_pkg::setup_addr_t   descriptor_base,
    input  setup_mem_pkg::setup_addr_t   descriptor_size,
    input  logic                         cu_flush,
    input  logic                         response_valid,
    input  logic                         request_ready,
    output logic                         request_valid,
    output setup_mem_pkg::setup_addr_t   request_address,
    output setup_mem_pkg::request_kind_t request_kind,
    output logic                         done
);

    import setup_mem_pkg::*;
    import setup_ctrl_pkg::*;

    logic          descriptor_start;
    logic          flush_seen;
    logic          responses_zero;
    setup_addr_t   base_address;
    setup_count_t  read_first;
    setup_count_t  read_count;
    setup_phase_t  phase;
    logic          counter_load;
    logic          engine_start;
    logic          engine_pause;
    logic          engine_done;
    logic          push;
    setup_addr_t   push_address;
    request_kind_t push_kind;
    logic          fifo_empty;
    logic          fifo_prog_full;

    // --------------------------------------------------
    // Descriptor, flush and response side
    // --------------------------------------------------
    setup_input_stage u_input (
        .ap_clk           (ap_clk),
        .areset_cu_setup  (areset_cu_setup),
        .descriptor_valid (descriptor_valid),
        .descriptor_base  (descriptor_base),
        .descriptor_size  (descriptor_size),
        .cu_flush         (cu_flush),
        .response_valid   (response_valid),
        .phase            (phase),
        .counter_load     (counter_load),
        .descriptor_start (descriptor_start),
        .flush_seen       (flush_seen),
        .base_address     (base_address),
        .read_first       (read_first),
        .read_count       (read_count),
        .responses_zero   (responses_zero)
    );

    setup_sequencer u_sequencer (
        .ap_clk           (ap_clk),
        .areset_cu_setup  (areset_cu_setup),
        .descriptor_start (descriptor_start),
        .flush_seen       (flush_seen),
        .engine_done      (engine_done),
        .responses_zero   (responses_zero),
        .fifo_empty       (fifo_empty),
        .fifo_prog_full   (fifo_prog_full),
        .phase            (phase),
        .counter_load     (counter_load),
        .engine_start     (engine_start),
        .engine_pause     (engine_pause),
        .done             (done)
    );

    read_request_engine u_engine (
        .ap_clk          (ap_clk),
        .areset_cu_setup (areset_cu_setup),
        .engine_start    (engine_start),
        .engine_pause    (engine_pause),
        .phase           (phase),
        .base_address    (base_address),
        .read_first      (read_first),
        .read_count      (read_count),
        .push            (push),
        .push_address    (push_address),
        .push_kind       (push_kind),
        .engine_done     (engine_done)
    );

    // --------------------------------------------------
    // Outgoing requests
    // --------------------------------------------------
    request_fifo u_fifo (
        .ap_clk          (ap_clk),
        .areset_cu_setup (areset_cu_setup),
        .push            (push),
        .push_address    (push_address),
        .push_kind       (push_kind),
        .request_ready   (request_ready),
        .request_valid   (request_valid),
        .request_address (request_address),
        .request_kind    (request_kind),
        .empty           (fifo_empty),
        .prog_full       (fifo_prog_full)
    );

endmodule : cu_setup_top

// ==== cu_setup_assertions.sv ====
`timescale 1ns/1ps

module cu_setup_assertions (
    input logic                         ap_clk,
    input logic                         areset_cu_setup,
    input logic                         request_valid,
    input logic                         request_ready,
    input setup_mem_pkg::setup_addr_t   request_address,
    input setup_mem_pkg::request_kind_t request_kind,
    input logic                         done
);

    int failures = 0;

    // --------------------------------------------------
    // Request port
    // --------------------------------------------------
    a_valid_known: assert property (
        @(posedge ap_clk) disable iff (areset_cu_setup)
        !$isunknown(request_valid)
    ) else begin
        $error("request_valid is unknown after reset");
        failures++;
    end

    // Head of the FIFO holds while the consumer stalls
    a_stall_stable: assert property (
        @(posedge ap_clk) disable iff (areset_cu_setup)
        request_valid && !request_ready |=>
            request_valid && $stable(request_address) && $stable(request_kind)
    ) else begin
        $error("Stalled request changed or was dropped");
        failures++;
    end

    // Job end only once the queue has drained
    a_done_idle: assert property (
        @(posedge ap_clk) disable iff (areset_cu_setup)
        !(done && request_valid)
    ) else begin
        $error("done rose while a request was still pending");
        failures++;
    end

endmodule : cu_setup_assertions

bind cu_setup_top cu_setup_assertions u_assertions (
    .ap_clk          (ap_clk),
    .areset_cu_setup (areset_cu_setup),
    .request_valid   (request_valid),
    .request_ready   (request_ready),
    .request_address (request_address),
    .request_kind    (request_kind),
    .done            (done)
);

// ==== tb_cu_setup.sv ====
`timescale 1ns/1ps
`include "cu_setup_params.svh"

module tb_cu_setup;

    import setup_mem_pkg::*;

    localparam int JOB_COUNT = 4;
    localparam int CLK_HALF  = 10;

    logic          ap_clk;
    logic          areset_cu_setup;
    logic          descriptor_valid;
    setup_addr_t   descriptor_base;
    setup_addr_t   descriptor_size;
    logic          cu_flush;
    logic          response_valid;
    logic          request_ready;
    logic          request_valid;
    setup_addr_t   request_address;
    request_kind_t request_kind;
    logic          done;

    integer                 seed = 62510;
    integer                 rand_word;
    logic [3:0]             response_pipe;
    setup_addr_t            cur_base;
    setup_addr_t            cur_size;
    int unsigned            job_first = 0;
    int unsigned            accepted = 0;
    int unsigned            response_total = 0;
    int unsigned            done_count = 0;
    logic                   flush_sent;
    logic [`SETUP_ADDR_W:0] expected_word;
    setup_addr_t            expected_address;
    request_kind_t          expected_kind;

    cu_setup_top dut0 (
        .ap_clk           (ap_clk),
        .areset_cu_setup  (areset_cu_setup),
        .descriptor_valid (descriptor_valid),
        .descriptor_base  (descriptor_base),
        .descriptor_size  (descriptor_size),
        .cu_flush         (cu_flush),
        .response_valid   (response_valid),
        .request_ready    (request_ready),
        .request_valid    (request_valid),
        .request_address  (request_address),
        .request_kind     (request_kind),
        .done             (done)
    );

    initial ap_clk = 1'b0;
    always #CLK_HALF ap_clk = ~ap_clk;

    // --------------------------------------------------
    // Job table and reference model
    // --------------------------------------------------
    function automatic setup_addr_t job_base_word(input int j);
        case (j)
            0:       return 64'h0000_0001_0000_0000;
            1:       return 64'h0000_0000_8000_0040;
            2:       return 64'h0000_0000_0000_1000;
            default: return 64'h0000_00ff_ffff_fff0;
        endcase
    endfunction

    // Flush end in the high word, twice the program count in the low word
    function automatic setup_addr_t job_size_word(input int j);
        case (j)
            0:       return {32'd20, 32'd20};
            1:       return {32'd46, 32'd81};
            2:       return {32'd5, 32'd1};
            default: return {32'd3, 32'd16};
        endcase
    endfunction

    // Program entries plus flush entries, which end at the flush end
    function automatic int unsigned requests_in_job(input setup_addr_t size);
        setup_count_t prog;
        setup_count_t flush_end;
        prog      = size[`SETUP_DATA_W-1:0] >> 1;
        flush_end = size[`SETUP_ADDR_W-1:`SETUP_DATA_W];
        if (flush_end > prog) begin
            return flush_end;
        end
        return prog;
    endfunction

    // Address and kind of request n of a job with the kind in the top bit
    function automatic logic [`SETUP_ADDR_W:0] expected_request(
        input setup_addr_t base,
        input setup_addr_t size,
        input int unsigned n
    );
        setup_count_t prog;
        setup_addr_t  addr;
        prog = size[`SETUP_DATA_W-1:0] >> 1;
        addr = base + (setup_addr_t'(n) << `SETUP_WORD_SHIFT);
        // Flush indices carry on right after the program entries
        if (n < prog) begin
            return {kind_program, addr};
        end
        return {kind_flush, addr};
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Some tests failed");
        $fatal(1);
    endtask

    // --------------------------------------------------
    // Ready source, responder and observers
    // --------------------------------------------------
    always @(posedge ap_clk) begin
        rand_word = $random(seed);
        request_ready <= rand_word[0];
    end

    // Each accepted request is answered five cycles later
    always @(posedge ap_clk) begin
        if (areset_cu_setup) begin
            response_pipe  <= '0;
            response_valid <= 1'b0;
        end else begin
            response_pipe  <= {response_pipe[2:0], request_valid & request_ready};
            response_valid <= response_pipe[3];
        end
        if (!areset_cu_setup && response_valid) begin
            response_total <= response_total + 1;
        end
    end

    always @(posedge ap_clk) begin
        if (!areset_cu_setup && request_valid && request_ready) begin
            assert (accepted - job_first < requests_in_job(cur_size)) else
                report_failure("A request was issued past the end of the job");
            expected_word    = expected_request(cur_base, cur_size, accepted - job_first);
            expected_address = expected_word[`SETUP_ADDR_W-1:0];
            expected_kind    = request_kind_t'(expected_word[`SETUP_ADDR_W]);
            assert (request_address == expected_address) else
                report_failure($sformatf("ERROR request_address expected %h got %h",
                                         expected_address, request_address));
            assert (request_kind == expected_kind) else
                report_failure($sformatf("ERROR request_kind expected %h got %h",
                                         expected_kind, request_kind));
            accepted <= accepted + 1;
        end
    end

    always @(posedge ap_clk) begin
        if (!areset_cu_setup && done) begin
            assert (flush_sent) else
                report_failure("done pulsed before the flush phase was requested");
            assert (response_total == accepted) else
                report_failure("done pulsed while responses were still outstanding");
            done_count <= done_count + 1;
        end
    end

    // --------------------------------------------------
    // Stimulus
    // --------------------------------------------------
    task automatic run_job(input int j);
        int unsigned prog;
        int unsigned total;
        int unsigned done_before;
        cur_base    = job_base_word(j);
        cur_size    = job_size_word(j);
        prog        = cur_size[`SETUP_DATA_W-1:0] >> 1;
        total       = requests_in_job(cur_size);
        job_first   = accepted;
        done_before = done_count;
        flush_sent <= 1'b0;
        @(posedge ap_clk);
        descriptor_base  <= cur_base;
        descriptor_size  <= cur_size;
        descriptor_valid <= 1'b1;
        repeat (2) @(posedge ap_clk);
        descriptor_valid <= 1'b0;
        while (accepted - job_first < prog) begin
            @(posedge ap_clk);
        end
        // Nothing more may leave without cu_flush
        repeat (200) @(posedge ap_clk);
        assert (accepted - job_first == prog) else
            report_failure($sformatf("ERROR program request count expected %h got %h",
                                     prog, accepted - job_first));
        assert (done_count == done_before) else
            report_failure("done pulsed although cu_flush was never given");
        flush_sent <= 1'b1;
        cu_flush   <= 1'b1;
        @(posedge ap_clk);
        cu_flush <= 1'b0;
        while (done_count == done_before) begin
            @(posedge ap_clk);
        end
        repeat (20) @(posedge ap_clk);
        assert (accepted - job_first == total) else
            report_failure($sformatf("ERROR request count expected %h got %h",
                                     total, accepted - job_first));
        assert (done_count == done_before + 1) else
            report_failure("done pulsed more than once for one job");
    endtask

    initial begin : watchdog
        int unsigned budget;
        budget = 2000;
        for (int j = 0; j < JOB_COUNT; j++) begin
            budget += 40 * requests_in_job(job_size_word(j));
        end
        repeat (budget) @(posedge ap_clk);
        report_failure("Timeout, the jobs did not complete in time");
    end

    initial begin
        areset_cu_setup  = 1'b1;
        descriptor_valid = 1'b0;
        descriptor_base  = '0;
        descriptor_size  = '0;
        cu_flush         = 1'b0;
        response_valid   = 1'b0;
        request_ready    = 1'b0;
        flush_sent       = 1'b0;
        cur_base         = '0;
        cur_size         = '0;
        repeat (8) @(posedge ap_clk);
        areset_cu_setup <= 1'b0;
        // No descriptor yet
        repeat (20) begin
            @(posedge ap_clk);
            assert (!request_valid && !done) else
                report_failure("request_valid or done rose while no descriptor was given");
        end
        for (int j = 0; j < JOB_COUNT; j++) begin
            run_job(j);
        end
        if (dut0.u_assertions.failures != 0) begin
            report_failure("A bound assertion on the DUT ports failed");
        end else begin
            $display("All tests passed");
            $finish;
        end
    end

endmodule : tb_cu_setup

// ==== vlog.f ====
+incdir+.
setup_mem_pkg.sv
setup_ctrl_pkg.sv
setup_input_stage.sv
setup_sequencer.sv
read_request_engine.sv
request_fifo.sv
cu_setup_top.sv
cu_setup_assertions.sv
tb_cu_setup.sv

// ==== Bender.yml ====
package:
  name: cu_setup

sources:
  - include_dirs:
      - .
    files:
      - setup_mem_pkg.sv
      - setup_ctrl_pkg.sv
      - setup_input_stage.sv
      - setup_sequencer.sv
      - read_request_engine.sv
      - request_fifo.sv
      - cu_setup_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - cu_setup_assertions.sv
      - tb_cu_setup.sv
